/* dispatch_unit.sv */
`timescale 1ns/1ps
`include "ooo_core_macros.svh"

module dispatch_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    // instruction input
    input  logic                        insn_valid,
    output logic                        insn_ready,
    input  ooo_pkg::opcode_e            insn_op,
    input  ooo_pkg::gpr_addr_t          insn_rd,
    input  ooo_pkg::gpr_addr_t          insn_rs1,
    input  ooo_pkg::gpr_addr_t          insn_rs2,
    input  logic [`WORD_WIDTH-1:0]      insn_imm,
    // rob allocation and lookup
    output logic                        alloc_en,
    output ooo_pkg::gpr_addr_t          alloc_rd,
    input  ooo_pkg::rob_tag_t           alloc_tag,
    input  logic                        rob_full,
    output ooo_pkg::rob_tag_t           rs1_tag,
    output ooo_pkg::rob_tag_t           rs2_tag,
    input  logic                        rs1_done,
    input  logic                        rs2_done,
    input  logic [`WORD_WIDTH-1:0]      rs1_rob_value,
    input  logic [`WORD_WIDTH-1:0]      rs2_rob_value,
    // gpr read
    output ooo_pkg::gpr_addr_t          gpr_rs1_addr,
    output ooo_pkg::gpr_addr_t          gpr_rs2_addr,
    input  logic [`WORD_WIDTH-1:0]      gpr_rs1_value,
    input  logic [`WORD_WIDTH-1:0]      gpr_rs2_value,
    // retirement
    input  logic                        commit_en,
    input  ooo_pkg::gpr_addr_t          commit_rd,
    input  ooo_pkg::rob_tag_t           commit_tag,
    // issue
    output logic                        alu_issue_en,
    output ooo_pkg::opcode_e            alu_op,
    output ooo_pkg::rob_tag_t           alu_tag,
    output logic [`WORD_WIDTH-1:0]      alu_a,
    output logic [`WORD_WIDTH-1:0]      alu_b,
    output logic                        mul_issue_en,
    output ooo_pkg::rob_tag_t           mul_tag,
    output logic [`WORD_WIDTH-1:0]      mul_a,
    output logic [`WORD_WIDTH-1:0]      mul_b
);

    // rename table where valid means the latest value lives in the rob
    logic [`GPR_NUM-1:0]    rt_valid;
    ooo_pkg::rob_tag_t      rt_tag [`GPR_NUM];

    logic                   need_rs2;
    logic                   rs1_avail;
    logic                   rs2_avail;
    logic                   accept;
    logic [`WORD_WIDTH-1:0] op_a;
    logic [`WORD_WIDTH-1:0] op_b;
    logic                   tag_in_use;

    assign rs1_tag      = rt_tag[insn_rs1];
    assign rs2_tag      = rt_tag[insn_rs2];
    assign gpr_rs1_addr = insn_rs1;
    assign gpr_rs2_addr = insn_rs2;

    assign need_rs2   = (insn_op != ooo_pkg::op_addi);
    assign rs1_avail  = !rt_valid[insn_rs1] || rs1_done;
    assign rs2_avail  = !rt_valid[insn_rs2] || rs2_done || !need_rs2;
    assign insn_ready = !rob_full && rs1_avail && rs2_avail;
    assign accept     = insn_valid && insn_ready;

    assign op_a = rt_valid[insn_rs1] ? rs1_rob_value : gpr_rs1_value;
    assign op_b = !need_rs2 ? insn_imm :
                  rt_valid[insn_rs2] ? rs2_rob_value : gpr_rs2_value;

    assign alloc_en = accept;
    assign alloc_rd = insn_rd;

    assign alu_issue_en = accept && (insn_op != ooo_pkg::op_mul);
    assign alu_op       = insn_op;
    assign alu_tag      = alloc_tag;
    assign alu_a        = op_a;
    assign alu_b        = op_b;
    assign mul_issue_en = accept && (insn_op == ooo_pkg::op_mul);
    assign mul_tag      = alloc_tag;
    assign mul_a        = op_a;
    assign mul_b        = op_b;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rt_valid <= '0;
        end else begin
            // clear only if no younger writer took the register
            if (commit_en && rt_valid[commit_rd] && rt_tag[commit_rd] == commit_tag)
                rt_valid[commit_rd] <= 1'b1 ^ 1'b1;
            if (accept)
                rt_valid[insn_rd] <= 1'b1;  // new rename wins over the clear
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            rt_tag[insn_rd] <= alloc_tag;
    end

    // any live mapping onto the tail entry
    always_comb begin
        tag_in_use = 1'b0;
        for (int i = 0; i < `GPR_NUM; i++) begin
            if (rt_valid[i] && rt_tag[i] == alloc_tag)
                tag_in_use = 1'b1;
        end
    end

    // an accepted instruction only lands on a rob entry nobody still names
    alloc_tag_unused: assert property (@(posedge clk) disable iff (!rst_n)
        alloc_en |-> !tag_in_use);

endmodule

/* exec_units.sv */
`timescale 1ns/1ps
`include "ooo_core_macros.svh"

module exec_units (
    input  logic                        clk,
    input  logic                        rst_n,
    // alu issue
    input  logic                        alu_issue_en,
    input  ooo_pkg::opcode_e            alu_op,
    input  ooo_pkg::rob_tag_t           alu_tag,
    input  logic [`WORD_WIDTH-1:0]      alu_a,
    input  logic [`WORD_WIDTH-1:0]      alu_b,
    // mul issue
    input  logic                        mul_issue_en,
    input  ooo_pkg::rob_tag_t           mul_tag,
    input  logic [`WORD_WIDTH-1:0]      mul_a,
    input  logic [`WORD_WIDTH-1:0]      mul_b,
    // writeback
    output logic                        alu_wb_valid,
    output ooo_pkg::rob_tag_t           alu_wb_tag,
    output logic [`WORD_WIDTH-1:0]      alu_wb_value,
    output logic                        mul_wb_valid,
    output ooo_pkg::rob_tag_t           mul_wb_tag,
    output logic [`WORD_WIDTH-1:0]      mul_wb_value
);

    logic [`WORD_WIDTH-1:0]     alu_res;
    logic [`WORD_WIDTH-1:0]     mul_prod;   // low half only
    logic [`MUL_LATENCY-1:0]    mul_vld;
    ooo_pkg::rob_tag_t          mul_tg  [`MUL_LATENCY];
    logic [`WORD_WIDTH-1:0]     mul_res [`MUL_LATENCY];

    always_comb begin
        case (alu_op)
            ooo_pkg::op_add,
            ooo_pkg::op_addi: alu_res = alu_a + alu_b;  // b carries imm for addi
            ooo_pkg::op_sub:  alu_res = alu_a - alu_b;
            ooo_pkg::op_and:  alu_res = alu_a & alu_b;
            ooo_pkg::op_xor:  alu_res = alu_a ^ alu_b;
            default:          alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alu_wb_valid <= 1'b0;
        end else begin
            alu_wb_valid <= alu_issue_en;
        end
    end

    always_ff @(posedge clk) begin
        alu_wb_tag   <= alu_tag;
        alu_wb_value <= alu_res;
    end

    assign mul_prod = mul_a * mul_b;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mul_vld <= '0;
        end else begin
            mul_vld <= {mul_vld[`MUL_LATENCY-2:0], mul_issue_en};
        end
    end

    // payload shifts alongside the valid bits
    always_ff @(posedge clk) begin
        mul_tg[0]  <= mul_tag;
        mul_res[0] <= mul_prod;
        for (int i = 1; i < `MUL_LATENCY; i++) begin
            mul_tg[i]  <= mul_tg[i-1];
            mul_res[i] <= mul_res[i-1];
        end
    end

    assign mul_wb_valid = mul_vld[`MUL_LATENCY-1];
    assign mul_wb_tag   = mul_tg[`MUL_LATENCY-1];
    assign mul_wb_value = mul_res[`MUL_LATENCY-1];

endmodule

/* gpr_file.sv */
`timescale 1ns/1ps
`include "ooo_core_macros.svh"

module gpr_file (
    input  logic                        clk,
    input  logic                        rst_n,
    // retirement write port
    input  logic                        commit_en,
    input  ooo_pkg::gpr_addr_t          commit_rd,
    input  logic [`WORD_WIDTH-1:0]      commit_value,
    // dispatch read ports
    input  ooo_pkg::gpr_addr_t          rs1_addr,
    input  ooo_pkg::gpr_addr_t          rs2_addr,
    output logic [`WORD_WIDTH-1:0]      rs1_value,
    output logic [`WORD_WIDTH-1:0]      rs2_value
);

    logic [`WORD_WIDTH-1:0] regs [`GPR_NUM];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `GPR_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (commit_en) begin
            regs[commit_rd] <= commit_value;
        end
    end

    assign rs1_value = regs[rs1_addr];
    assign rs2_value = regs[rs2_addr];

endmodule

/* ooo_core.f */
+incdir+.
ooo_pkg.sv
gpr_file.sv
exec_units.sv
rob.sv
dispatch_unit.sv
ooo_core.sv
tb_ooo_core.sv

/* ooo_core.sv */
`timescale 1ns/1ps
`include "ooo_core_macros.svh"

module ooo_core (
    input  logic                        clk,
    input  logic                        rst_n,
    // instruction input
    input  logic                        insn_valid,
    output logic                        insn_ready,
    input  ooo_pkg::opcode_e            insn_op,
    input  ooo_pkg::gpr_addr_t          insn_rd,
    input  ooo_pkg::gpr_addr_t          insn_rs1,
    input  ooo_pkg::gpr_addr_t          insn_rs2,
    input  logic [`WORD_WIDTH-1:0]      insn_imm,
    // retirement
    output logic                        commit_valid,
    output ooo_pkg::gpr_addr_t          commit_rd,
    output logic [`WORD_WIDTH-1:0]      commit_value
);

    // allocation and lookup
    logic                       alloc_en;
    ooo_pkg::gpr_addr_t         alloc_rd;
    ooo_pkg::rob_tag_t          alloc_tag;
    logic                       rob_full;
    ooo_pkg::rob_tag_t          rs1_tag;
    ooo_pkg::rob_tag_t          rs2_tag;
    logic                       rs1_done;
    logic                       rs2_done;
    logic [`WORD_WIDTH-1:0]     rs1_rob_value;
    logic [`WORD_WIDTH-1:0]     rs2_rob_value;
    ooo_pkg::rob_tag_t          commit_tag;
    // gpr read
    ooo_pkg::gpr_addr_t         gpr_rs1_addr;
    ooo_pkg::gpr_addr_t         gpr_rs2_addr;
    logic [`WORD_WIDTH-1:0]     gpr_rs1_value;
    logic [`WORD_WIDTH-1:0]     gpr_rs2_value;
    // issue
    logic                       alu_issue_en;
    ooo_pkg::opcode_e           alu_op;
    ooo_pkg::rob_tag_t          alu_tag;
    logic [`WORD_WIDTH-1:0]     alu_a;
    logic [`WORD_WIDTH-1:0]     alu_b;
    logic                       mul_issue_en;
    ooo_pkg::rob_tag_t          mul_tag;
    logic [`WORD_WIDTH-1:0]     mul_a;
    logic [`WORD_WIDTH-1:0]     mul_b;
    // writeback
    logic                       alu_wb_valid;
    ooo_pkg::rob_tag_t          alu_wb_tag;
    logic [`WORD_WIDTH-1:0]     alu_wb_value;
    logic                       mul_wb_valid;
    ooo_pkg::rob_tag_t          mul_wb_tag;
    logic [`WORD_WIDTH-1:0]     mul_wb_value;

    dispatch_unit u_dispatch_unit (
        .clk            (clk            ),
        .rst_n          (rst_n          ),
        .insn_valid     (insn_valid     ),
        .insn_ready     (insn_ready     ),
        .insn_op        (insn_op        ),
        .insn_rd        (insn_rd        ),
        .insn_rs1       (insn_rs1       ),
        .insn_rs2       (insn_rs2       ),
        .insn_imm       (insn_imm       ),
        .alloc_en       (alloc_en       ),
        .alloc_rd       (alloc_rd       ),
        .alloc_tag      (alloc_tag      ),
        .rob_full       (rob_full       ),
        .rs1_tag        (rs1_tag        ),
        .rs2_tag        (rs2_tag        ),
        .rs1_done       (rs1_done       ),
        .rs2_done       (rs2_done       ),
        .rs1_rob_value  (rs1_rob_value  ),
        .rs2_rob_value  (rs2_rob_value  ),
        .gpr_rs1_addr   (gpr_rs1_addr   ),
        .gpr_rs2_addr   (gpr_rs2_addr   ),
        .gpr_rs1_value  (gpr_rs1_value  ),
        .gpr_rs2_value  (gpr_rs2_value  ),
        .commit_en      (commit_valid   ),
        .commit_rd      (commit_rd      ),
        .commit_tag     (commit_tag     ),
        .alu_issue_en   (alu_issue_en   ),
        .alu_op         (alu_op         ),
        .alu_tag        (alu_tag        ),
        .alu_a          (alu_a          ),
        .alu_b          (alu_b          ),
        .mul_issue_en   (mul_issue_en   ),
        .mul_tag        (mul_tag        ),
        .mul_a          (mul_a          ),
        .mul_b          (mul_b          )
    );

    exec_units u_exec_units (
        .clk            (clk            ),
        .rst_n          (rst_n          ),
        .alu_issue_en   (alu_issue_en   ),
        .alu_op         (alu_op         ),
        .alu_tag        (alu_tag        ),
        .alu_a          (alu_a          ),
        .alu_b          (alu_b          ),
        .mul_issue_en   (mul_issue_en   ),
        .mul_tag        (mul_tag        ),
        .mul_a          (mul_a          ),
        .mul_b          (mul_b          ),
        .alu_wb_valid   (alu_wb_valid   ),
        .alu_wb_tag     (alu_wb_tag     ),
        .alu_wb_value   (alu_wb_value   ),
        .mul_wb_valid   (mul_wb_valid   ),
        .mul_wb_tag     (mul_wb_tag     ),
        .mul_wb_value   (mul_wb_value   )
    );

    rob u_rob (
        .clk            (clk            ),
        .rst_n          (rst_n          ),
        .alloc_en       (alloc_en       ),
        .alloc_rd       (alloc_rd       ),
        .alloc_tag      (alloc_tag      ),
        .rob_full       (rob_full       ),
        .alu_wb_valid   (alu_wb_valid   ),
        .alu_wb_tag     (alu_wb_tag     ),
        .alu_wb_value   (alu_wb_value   ),
        .mul_wb_valid   (mul_wb_valid   ),
        .mul_wb_tag     (mul_wb_tag     ),
        .mul_wb_value   (mul_wb_value   ),
        .rs1_tag        (rs1_tag        ),
        .rs2_tag        (rs2_tag        ),
        .rs1_done       (rs1_done       ),
        .rs2_done       (rs2_done       ),
        .rs1_value      (rs1_rob_value  ),
        .rs2_value      (rs2_rob_value  ),
        .commit_en      (commit_valid   ),
        .commit_rd      (commit_rd      ),
        .commit_tag     (commit_tag     ),
        .commit_value   (commit_value   )
    );

    gpr_file u_gpr_file (
        .clk            (clk            ),
        .rst_n          (rst_n          ),
        .commit_en      (commit_valid   ),
        .commit_rd      (commit_rd      ),
        .commit_value   (commit_value   ),
        .rs1_addr       (gpr_rs1_addr   ),
        .rs2_addr       (gpr_rs2_addr   ),
        .rs1_value      (gpr_rs1_value  ),
        .rs2_value      (gpr_rs2_value  )
    );

endmodule

/* ooo_core_macros.svh */
`ifndef OOO_CORE_MACROS_SVH
`define OOO_CORE_MACROS_SVH

`define WORD_WIDTH      32
`define GPR_NUM         8
`define GPR_ADDR_WIDTH  3

`define ROB_DEPTH       4
`define ROB_TAG_WIDTH   2   // log2 of rob depth

`define MUL_LATENCY     4   // multiplier pipeline stages

`endif

/* ooo_pkg.sv */
`include "ooo_core_macros.svh"

package ooo_pkg;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_xor,
        op_addi,    // rs1 + imm
        op_mul
    } opcode_e;

    typedef enum logic [1:0] {rob_free, rob_busy, rob_done} rob_state_e;

    typedef logic [`ROB_TAG_WIDTH-1:0]  rob_tag_t;
    typedef logic [`GPR_ADDR_WIDTH-1:0] gpr_addr_t;

endpackage

/* rob.sv */
`timescale 1ns/1ps
`include "ooo_core_macros.svh"

module rob (
    input  logic                        clk,
    input  logic                        rst_n,
    // allocation
    input  logic                        alloc_en,
    input  ooo_pkg::gpr_addr_t          alloc_rd,
    output ooo_pkg::rob_tag_t           alloc_tag,
    output logic                        rob_full,
    // writeback
    input  logic                        alu_wb_valid,
    input  ooo_pkg::rob_tag_t           alu_wb_tag,
    input  logic [`WORD_WIDTH-1:0]      alu_wb_value,
    input  logic                        mul_wb_valid,
    input  ooo_pkg::rob_tag_t           mul_wb_tag,
    input  logic [`WORD_WIDTH-1:0]      mul_wb_value,
    // operand lookup
    input  ooo_pkg::rob_tag_t           rs1_tag,
    input  ooo_pkg::rob_tag_t           rs2_tag,
    output logic                        rs1_done,
    output logic                        rs2_done,
    output logic [`WORD_WIDTH-1:0]      rs1_value,
    output logic [`WORD_WIDTH-1:0]      rs2_value,
    // commit
    output logic                        commit_en,
    output ooo_pkg::gpr_addr_t          commit_rd,
    output ooo_pkg::rob_tag_t           commit_tag,
    output logic [`WORD_WIDTH-1:0]      commit_value
);

    ooo_pkg::rob_state_e        state [`ROB_DEPTH];
    ooo_pkg::gpr_addr_t         dst   [`ROB_DEPTH];
    logic [`WORD_WIDTH-1:0]     value [`ROB_DEPTH];

    ooo_pkg::rob_tag_t          head;
    ooo_pkg::rob_tag_t          tail;
    logic [`ROB_TAG_WIDTH:0]    count;
    logic                       retire;

    assign alloc_tag = tail;
    assign rob_full  = (count == (`ROB_TAG_WIDTH+1)'(`ROB_DEPTH));
    assign retire    = (state[head] == ooo_pkg::rob_done);

    assign rs1_done  = (state[rs1_tag] == ooo_pkg::rob_done);
    assign rs2_done  = (state[rs2_tag] == ooo_pkg::rob_done);
    assign rs1_value = value[rs1_tag];
    assign rs2_value = value[rs2_tag];

    // entry stays done until the commit cycle so lookups still hit it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                state[i] <= ooo_pkg::rob_free;
            end
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            commit_en <= 1'b0;
        end else begin
            commit_en <= retire;
            if (retire)
                head <= head + 1'b1;
            if (commit_en)
                state[commit_tag] <= ooo_pkg::rob_free;
            if (alloc_en) begin
                state[tail] <= ooo_pkg::rob_busy;
                tail        <= tail + 1'b1;
            end
            if (alu_wb_valid)
                state[alu_wb_tag] <= ooo_pkg::rob_done;
            if (mul_wb_valid)
                state[mul_wb_tag] <= ooo_pkg::rob_done;
            case ({alloc_en, commit_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en)
            dst[tail] <= alloc_rd;
        if (alu_wb_valid)
            value[alu_wb_tag] <= alu_wb_value;
        if (mul_wb_valid)
            value[mul_wb_tag] <= mul_wb_value;
        if (retire) begin
            commit_rd    <= dst[head];
            commit_tag   <= head;
            commit_value <= value[head];
        end
    end

    // a result may only land on an entry still waiting for it
    alu_wb_busy: assert property (@(posedge clk) disable iff (!rst_n)
        alu_wb_valid |-> state[alu_wb_tag] == ooo_pkg::rob_busy);
    mul_wb_busy: assert property (@(posedge clk) disable iff (!rst_n)
        mul_wb_valid |-> state[mul_wb_tag] == ooo_pkg::rob_busy);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build with verilator, run, then scan the log for the failure line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_ooo_core \
    -f ooo_core.f -o tb_ooo_core || { echo "build error"; exit 1; }
./obj_dir/tb_ooo_core > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Simulation passed" sim.log && { echo "PASS"; exit 0; } || { echo "FAIL"; exit 1; }

/* tb_ooo_core.sv */
`timescale 1ns/1ps
`include "ooo_core_macros.svh"

module tb_ooo_core;

    localparam int NUM_RANDOM    = 300;
    localparam int SEND_TIMEOUT  = 200;  // cycles per instruction
    localparam int DRAIN_TIMEOUT = 500;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       insn_valid;
    logic                       insn_ready;
    ooo_pkg::opcode_e           insn_op;
    ooo_pkg::gpr_addr_t         insn_rd;
    ooo_pkg::gpr_addr_t         insn_rs1;
    ooo_pkg::gpr_addr_t         insn_rs2;
    logic [`WORD_WIDTH-1:0]     insn_imm;
    logic                       commit_valid;
    ooo_pkg::gpr_addr_t         commit_rd;
    logic [`WORD_WIDTH-1:0]     commit_value;

    // reference model state
    logic [`WORD_WIDTH-1:0]     ref_regs [`GPR_NUM];
    ooo_pkg::gpr_addr_t         exp_rd_q [$];
    logic [`WORD_WIDTH-1:0]     exp_val_q [$];
    logic                       exp_valid;
    ooo_pkg::gpr_addr_t         exp_rd;
    logic [`WORD_WIDTH-1:0]     exp_value;
    int                         acc_cnt;
    int                         com_cnt;
    int                         sent_cnt = 0;
    logic                       seen_accept;
    logic                       full_stall_seen;
    int                         seed = 48;

    ooo_core i_dut (
        .clk          (clk          ),
        .rst_n        (rst_n        ),
        .insn_valid   (insn_valid   ),
        .insn_ready   (insn_ready   ),
        .insn_op      (insn_op      ),
        .insn_rd      (insn_rd      ),
        .insn_rs1     (insn_rs1     ),
        .insn_rs2     (insn_rs2     ),
        .insn_imm     (insn_imm     ),
        .commit_valid (commit_valid ),
        .commit_rd    (commit_rd    ),
        .commit_value (commit_value )
    );

    always #5 clk = ~clk;

    function automatic logic [`WORD_WIDTH-1:0] compute_result(
        input ooo_pkg::opcode_e       op,
        input logic [`WORD_WIDTH-1:0] a,
        input logic [`WORD_WIDTH-1:0] b,
        input logic [`WORD_WIDTH-1:0] imm
    );
        logic [2*`WORD_WIDTH-1:0] wide;
        wide = '0;
        case (op)
            ooo_pkg::op_add:  return a + b;
            ooo_pkg::op_sub:  return a - b;
            ooo_pkg::op_and:  return a & b;
            ooo_pkg::op_xor:  return a ^ b;
            ooo_pkg::op_addi: return a + imm;
            ooo_pkg::op_mul: begin
                wide = {{`WORD_WIDTH{1'b0}}, a} * {{`WORD_WIDTH{1'b0}}, b};
                return wide[`WORD_WIDTH-1:0];  // low half of the product
            end
            default:          return '0;
        endcase
    endfunction

    // program-order model updated at each accepted instruction
    always @(posedge clk) begin : ref_model
        logic [`WORD_WIDTH-1:0] result;
        if (!rst_n) begin
            for (int i = 0; i < `GPR_NUM; i++) begin
                ref_regs[i] = '0;
            end
            exp_rd_q.delete();
            exp_val_q.delete();
            acc_cnt         <= 0;
            com_cnt         <= 0;
            seen_accept     <= 1'b0;
            full_stall_seen <= 1'b0;
            exp_valid       <= 1'b0;
            exp_rd          <= '0;
            exp_value       <= '0;
        end else begin
            if (commit_valid) begin
                com_cnt <= com_cnt + 1;
                if (exp_rd_q.size() > 0) begin
                    exp_rd_q.delete(0);
                    exp_val_q.delete(0);
                end
            end
            if (insn_valid && insn_ready) begin
                result = compute_result(insn_op, ref_regs[insn_rs1], ref_regs[insn_rs2],
                                        insn_imm);
                ref_regs[insn_rd] = result;
                exp_rd_q.push_back(insn_rd);
                exp_val_q.push_back(result);
                acc_cnt     <= acc_cnt + 1;
                seen_accept <= 1'b1;
            end
            if (insn_valid && !insn_ready && (acc_cnt - com_cnt == `ROB_DEPTH))
                full_stall_seen <= 1'b1;
            exp_valid <= (exp_rd_q.size() > 0);
            if (exp_rd_q.size() > 0) begin
                exp_rd    <= exp_rd_q[0];
                exp_value <= exp_val_q[0];
            end
        end
    end

    idle_commit_check: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_accept |-> !commit_valid)
    else begin
        $display("[ERROR] %0t commit_valid expected 0 got %b", $time, $sampled(commit_valid));
        $display("Simulation failed");
        $fatal(1);
    end

    idle_ready_check: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_accept |-> insn_ready)
    else begin
        $display("[ERROR] %0t insn_ready expected 1 got %b", $time, $sampled(insn_ready));
        $display("Simulation failed");
        $fatal(1);
    end

    commit_expected_check: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid |-> exp_valid)
    else begin
        $display("Commit seen at %0t while no instruction was outstanding", $time);
        $display("Simulation failed");
        $fatal(1);
    end

    commit_rd_check: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid && exp_valid |-> commit_rd == exp_rd)
    else begin
        $display("[ERROR] %0t commit_rd expected %0d got %0d", $time, $sampled(exp_rd),
                 $sampled(commit_rd));
        $display("Simulation failed");
        $fatal(1);
    end

    commit_value_check: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid && exp_valid |-> commit_value == exp_value)
    else begin
        $display("[ERROR] %0t commit_value expected %h got %h", $time, $sampled(exp_value),
                 $sampled(commit_value));
        $display("Simulation failed");
        $fatal(1);
    end

    // a full rob leaves no room for another instruction
    full_ready_check: assert property (@(posedge clk) disable iff (!rst_n)
        (acc_cnt - com_cnt == `ROB_DEPTH) |-> !insn_ready)
    else begin
        $display("[ERROR] %0t insn_ready expected 0 got %b", $time, $sampled(insn_ready));
        $display("Simulation failed");
        $fatal(1);
    end

    // starts and ends on a falling edge
    task automatic send_insn(
        input ooo_pkg::opcode_e       op,
        input ooo_pkg::gpr_addr_t     rd,
        input ooo_pkg::gpr_addr_t     rs1,
        input ooo_pkg::gpr_addr_t     rs2,
        input logic [`WORD_WIDTH-1:0] imm
    );
        int start;
        int waited;
        start      = acc_cnt;
        waited     = 0;
        insn_valid = 1'b1;
        insn_op    = op;
        insn_rd    = rd;
        insn_rs1   = rs1;
        insn_rs2   = rs2;
        insn_imm   = imm;
        do begin
            @(negedge clk);
            waited++;
            if (waited > SEND_TIMEOUT) begin
                $display("Instruction %0d was never accepted, timeout at %0t", sent_cnt, $time);
                $display("Simulation failed");
                $fatal(1);
            end
        end while (acc_cnt == start);
        insn_valid = 1'b0;
        sent_cnt++;
    endtask

    task automatic send_random_insn();
        logic [31:0]        rnd;
        ooo_pkg::opcode_e   op;
        ooo_pkg::gpr_addr_t rd;
        ooo_pkg::gpr_addr_t rs1;
        ooo_pkg::gpr_addr_t rs2;
        rnd = $random(seed);
        op  = ooo_pkg::opcode_e'(3'(rnd % 32'd6));
        rnd = $random(seed);
        rd  = rnd[2:0];
        rs1 = rnd[5:3];
        rs2 = rnd[8:6];
        rnd = $random(seed);
        send_insn(op, rd, rs1, rs2, rnd);
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (com_cnt != acc_cnt) begin
            @(negedge clk);
            waited++;
            if (waited > DRAIN_TIMEOUT) begin
                $display("Core did not drain, %0d of %0d committed at %0t", com_cnt, acc_cnt,
                         $time);
                $display("Simulation failed");
                $fatal(1);
            end
        end
    endtask

    initial begin
        logic [31:0] gap;
        rst_n      = 1'b0;
        insn_valid = 1'b0;
        insn_op    = ooo_pkg::op_add;
        insn_rd    = '0;
        insn_rs1   = '0;
        insn_rs2   = '0;
        insn_imm   = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);

        send_insn(ooo_pkg::op_addi, 3'd1, 3'd0, 3'd0, 32'd7);
        send_insn(ooo_pkg::op_addi, 3'd2, 3'd0, 3'd0, 32'd9);
        send_insn(ooo_pkg::op_mul,  3'd3, 3'd1, 3'd2, 32'd0);
        send_insn(ooo_pkg::op_add,  3'd4, 3'd1, 3'd2, 32'd0);  // independent of the mul
        send_insn(ooo_pkg::op_add,  3'd5, 3'd3, 3'd1, 32'd0);  // waits on r3
        wait_for_drain();

        // back-to-back muls fill the rob and stall the addi behind them
        send_insn(ooo_pkg::op_mul,  3'd6, 3'd1, 3'd2, 32'd0);
        send_insn(ooo_pkg::op_mul,  3'd7, 3'd2, 3'd2, 32'd0);
        send_insn(ooo_pkg::op_mul,  3'd4, 3'd1, 3'd1, 32'd0);
        send_insn(ooo_pkg::op_mul,  3'd0, 3'd2, 3'd1, 32'd0);
        send_insn(ooo_pkg::op_addi, 3'd5, 3'd1, 3'd0, 32'd3);
        wait_for_drain();

        for (int n = 0; n < NUM_RANDOM; n++) begin
            send_random_insn();
            gap = $random(seed);
            if (gap[1:0] == 2'b00)
                @(negedge clk);
        end
        wait_for_drain();

        if (!full_stall_seen) begin
            $display("The instruction input never stalled on a full reorder buffer");
            $display("Simulation failed");
            $fatal(1);
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule
